//--- common/vdp_super_defs.svh
`ifndef VDP_SUPER_DEFS_SVH
`define VDP_SUPER_DEFS_SVH

// ************************************************************
// frame geometry
// ************************************************************

// total columns and lines, blanking included.
`define FRAME_WIDTH_NTSC 858
`define FRAME_HEIGHT_NTSC 525
`define FRAME_WIDTH_PAL 864
`define FRAME_HEIGHT_PAL 625

// ************************************************************
// VRAM layout
// ************************************************************

// words from the start of one viewport line to the start of the next.
`define LINE_STRIDE_WORDS 256

// pixels held in one 32-bit word.
`define PIXELS_PER_WORD_8BPP 4
`define PIXELS_PER_WORD_4BPP 8

`endif

//--- common/vdp_super_pkg.sv
`default_nettype none

package vdp_super_pkg;

  // ************************************************************
  // raster and memory types
  // ************************************************************

  // a column or line number of the full frame, blanking included.
  typedef logic [9:0] coord_t;

  // word address into the 32-bit wide VRAM.
  typedef logic [17:0] vram_addr_t;

  // index into the colour palette.
  typedef logic [7:0] palette_idx_t;

  // ************************************************************
  // pixel formats
  // ************************************************************

  // high modes show one pixel per clock, mid mode shows each pixel for two clocks.
  typedef enum logic [1:0] {
    MODE_HIGH_8BPP = 2'd0,
    MODE_HIGH_4BPP = 2'd1,
    MODE_MID_8BPP  = 2'd2
  } super_mode_t;

endpackage

`default_nettype wire

//--- rtl/vdp_raster_counter.sv
`include "vdp_super_defs.svh"

`default_nettype none

module vdp_raster_counter
  import vdp_super_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   super_enable,
  input  logic   pal_mode,
  output coord_t cx,
  output coord_t cy
);

  // the standard only changes at a frame boundary so a frame is never cut short.
  logic   pal_q;
  coord_t last_col;
  coord_t last_line;

  assign last_col  = pal_q ? coord_t'(`FRAME_WIDTH_PAL - 1)
                           : coord_t'(`FRAME_WIDTH_NTSC - 1);
  assign last_line = pal_q ? coord_t'(`FRAME_HEIGHT_PAL - 1)
                           : coord_t'(`FRAME_HEIGHT_NTSC - 1);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cx    <= '0;
      cy    <= '0;
      pal_q <= 1'b0;
    end else if (!super_enable) begin
      cx <= '0;
      cy <= '0;
    end else if (cx == last_col) begin
      cx <= '0;
      if (cy == last_line) begin
        cy    <= '0;
        pal_q <= pal_mode;
      end else begin
        cy <= cy + 1'b1;
      end
    end else begin
      cx <= cx + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/vdp_window_fsm.sv
`default_nettype none

module vdp_window_fsm
  import vdp_super_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   super_enable,
  input  coord_t cx,
  input  coord_t cy,
  input  coord_t view_start_x,
  input  coord_t view_end_x,
  input  coord_t view_start_y,
  input  coord_t view_end_y,
  input  coord_t arb_start_x,
  input  coord_t arb_end_x,
  output logic   line_visible,
  output logic   pixel_visible,
  output logic   first_pixel,
  output logic   drawing,
  output coord_t line_index
);

  typedef enum logic [2:0] {
    IDLE,
    BLANK_LINE,
    LINE_WAIT,
    ACTIVE,
    LINE_DONE
  } win_state_t;

  win_state_t state;
  logic       line_start;
  logic       in_y;
  logic       in_x;

  assign line_start = (cx == '0);
  assign in_y       = (cy >= view_start_y) && (cy < view_end_y);
  assign in_x       = (cx >= view_start_x) && (cx < view_end_x);

  // the state only changes on a clock edge, so the line flag is a register too.
  assign line_visible  = (state == LINE_WAIT) || (state == ACTIVE) || (state == LINE_DONE);
  assign pixel_visible = ((state == LINE_WAIT) || (state == ACTIVE)) && in_x;
  assign first_pixel   = (state == LINE_WAIT) && (cx == view_start_x);

  // ************************************************************
  // window state
  // ************************************************************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state      <= IDLE;
      line_index <= '0;
    end else if (!super_enable) begin
      state      <= IDLE;
      line_index <= '0;
    end else if (line_start) begin
      if (in_y) begin
        state      <= LINE_WAIT;
        line_index <= (cy == view_start_y) ? coord_t'(0) : coord_t'(line_index + 1'b1);
      end else begin
        state <= BLANK_LINE;
      end
    end else begin
      case (state)
        LINE_WAIT: if (cx == view_start_x) state <= ACTIVE;
        ACTIVE:    if (!in_x) state <= LINE_DONE;
        default: ;
      endcase
    end
  end

  // ************************************************************
  // bus ownership
  // ************************************************************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      drawing <= 1'b0;
    end else if (!super_enable) begin
      drawing <= 1'b0;
    end else if ((cx == arb_start_x) && line_visible) begin
      drawing <= 1'b1;
    end else if (cx == arb_end_x) begin
      drawing <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- super_fetch/vdp_super_addr_gen.sv
`include "vdp_super_defs.svh"

`default_nettype none

module vdp_super_addr_gen
  import vdp_super_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        super_enable,
  input  super_mode_t mode,
  input  logic [16:0] page_addr,
  input  logic        pixel_visible,
  input  logic        first_pixel,
  input  coord_t      line_index,
  output vram_addr_t  vram_addr,
  output logic [2:0]  pixel_slot,
  output logic        slot_valid
);

  coord_t     pix_cnt;
  vram_addr_t line_base;
  coord_t     cnt_now;
  vram_addr_t base_now;
  vram_addr_t word_off;
  logic [2:0] slot_now;

  // the first pixel of a line restarts from the line base without a bubble.
  always_comb begin
    if (first_pixel) begin
      cnt_now  = '0;
      base_now = vram_addr_t'({1'b0, page_addr})
               + vram_addr_t'(line_index) * vram_addr_t'(`LINE_STRIDE_WORDS);
    end else begin
      cnt_now  = pix_cnt;
      base_now = line_base;
    end
  end

  // mid mode spends two clocks per byte, so it also covers eight clocks per word.
  always_comb begin
    case (mode)
      MODE_HIGH_4BPP, MODE_MID_8BPP: begin
        word_off = vram_addr_t'(cnt_now / `PIXELS_PER_WORD_4BPP);
        slot_now = 3'(cnt_now % `PIXELS_PER_WORD_4BPP);
      end
      default: begin
        word_off = vram_addr_t'(cnt_now / `PIXELS_PER_WORD_8BPP);
        slot_now = 3'(cnt_now % `PIXELS_PER_WORD_8BPP);
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pix_cnt    <= '0;
      line_base  <= '0;
      vram_addr  <= '0;
      pixel_slot <= '0;
      slot_valid <= 1'b0;
    end else if (!super_enable) begin
      pix_cnt    <= '0;
      line_base  <= '0;
      vram_addr  <= '0;
      pixel_slot <= '0;
      slot_valid <= 1'b0;
    end else begin
      slot_valid <= pixel_visible;
      if (pixel_visible) begin
        pix_cnt    <= cnt_now + 1'b1;
        line_base  <= base_now;
        vram_addr  <= base_now + word_off;
        pixel_slot <= slot_now;
      end
    end
  end

endmodule

`default_nettype wire

//--- super_fetch/vdp_super_pixel_unpack.sv
`default_nettype none

module vdp_super_pixel_unpack
  import vdp_super_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         super_enable,
  input  super_mode_t  mode,
  input  logic [31:0]  vram_data,
  input  logic [2:0]   pixel_slot,
  input  logic         slot_valid,
  input  palette_idx_t frame_col,
  output palette_idx_t palette_addr
);

  // slot and valid trail the address by one clock, as the data does.
  logic [2:0]   slot_q;
  logic         valid_q;
  palette_idx_t frame_col_q;
  palette_idx_t pixel;

  // ************************************************************
  // pixel select
  // ************************************************************

  always_comb begin
    case (mode)
      MODE_HIGH_4BPP: begin
        // low nibble is the left pixel of each byte.
        pixel = {4'h0, vram_data[{slot_q, 2'b00} +: 4]};
      end
      MODE_MID_8BPP: begin
        pixel = vram_data[{slot_q[2:1], 3'b000} +: 8];
      end
      default: begin
        pixel = vram_data[{slot_q[1:0], 3'b000} +: 8];
      end
    endcase
  end

  // ************************************************************
  // output register
  // ************************************************************

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      slot_q       <= '0;
      valid_q      <= 1'b0;
      frame_col_q  <= '0;
      palette_addr <= '0;
    end else if (!super_enable) begin
      slot_q       <= '0;
      valid_q      <= 1'b0;
      frame_col_q  <= '0;
      palette_addr <= '0;
    end else begin
      slot_q       <= pixel_slot;
      valid_q      <= slot_valid;
      frame_col_q  <= frame_col;
      palette_addr <= valid_q ? pixel : frame_col_q;
    end
  end

endmodule

`default_nettype wire

//--- rtl/vdp_super_res.sv
`default_nettype none

module vdp_super_res
  import vdp_super_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         super_enable,
  input  logic         pal_mode,
  input  super_mode_t  mode,
  input  logic [16:0]  page_addr,
  input  coord_t       view_start_x,
  input  coord_t       view_end_x,
  input  coord_t       view_start_y,
  input  coord_t       view_end_y,
  input  coord_t       arb_start_x,
  input  coord_t       arb_end_x,
  input  palette_idx_t frame_col,
  input  logic [31:0]  vram_data,
  output vram_addr_t   vram_addr,
  output palette_idx_t palette_addr,
  output logic         drawing,
  output coord_t       cx,
  output coord_t       cy
);

  logic       pixel_visible;
  logic       first_pixel;
  coord_t     line_index;
  logic [2:0] pixel_slot;
  logic       slot_valid;

  vdp_raster_counter u_raster_counter (
    .clk          (clk),
    .reset        (reset),
    .super_enable (super_enable),
    .pal_mode     (pal_mode),
    .cx           (cx),
    .cy           (cy)
  );

  vdp_window_fsm u_window_fsm (
    .clk           (clk),
    .reset         (reset),
    .super_enable  (super_enable),
    .cx            (cx),
    .cy            (cy),
    .view_start_x  (view_start_x),
    .view_end_x    (view_end_x),
    .view_start_y  (view_start_y),
    .view_end_y    (view_end_y),
    .arb_start_x   (arb_start_x),
    .arb_end_x     (arb_end_x),
    .line_visible  (),
    .pixel_visible (pixel_visible),
    .first_pixel   (first_pixel),
    .drawing       (drawing),
    .line_index    (line_index)
  );

  // the address leaves one clock after the column, VRAM answers one clock later.
  vdp_super_addr_gen u_addr_gen (
    .clk           (clk),
    .reset         (reset),
    .super_enable  (super_enable),
    .mode          (mode),
    .page_addr     (page_addr),
    .pixel_visible (pixel_visible),
    .first_pixel   (first_pixel),
    .line_index    (line_index),
    .vram_addr     (vram_addr),
    .pixel_slot    (pixel_slot),
    .slot_valid    (slot_valid)
  );

  vdp_super_pixel_unpack u_pixel_unpack (
    .clk          (clk),
    .reset        (reset),
    .super_enable (super_enable),
    .mode         (mode),
    .vram_data    (vram_data),
    .pixel_slot   (pixel_slot),
    .slot_valid   (slot_valid),
    .frame_col    (frame_col),
    .palette_addr (palette_addr)
  );

endmodule

`default_nettype wire

//--- testbench/tb_vdp_super_res.sv
`include "vdp_super_defs.svh"

`default_nettype none

module tb_vdp_super_res
  import vdp_super_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic         clk;
  logic         reset;
  logic         super_enable;
  logic         pal_mode;
  super_mode_t  mode;
  logic [16:0]  page_addr;
  coord_t       view_start_x;
  coord_t       view_end_x;
  coord_t       view_start_y;
  coord_t       view_end_y;
  coord_t       arb_start_x;
  coord_t       arb_end_x;
  palette_idx_t frame_col;
  logic [31:0]  vram_data = '0;
  vram_addr_t   vram_addr;
  palette_idx_t palette_addr;
  logic         drawing;
  coord_t       cx;
  coord_t       cy;

  logic [31:0] vram [0:(1 << 18) - 1];
  int          test_errors;
  int          errors;
  int          checks;
  int          tests_passed;
  int          tests_failed;

  vdp_super_res u_dut (.*);

  always #5 clk = ~clk;

  // the VRAM model answers each address one clock later.
  always @(posedge clk) begin
    vram_data <= vram[vram_addr];
  end

  // ************************************************************
  // stimulus and reference model
  // ************************************************************

  function automatic logic [31:0] lcg_next(input logic [31:0] value);
    return value * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fill_vram();
    logic [31:0] lcg_state;
    lcg_state = 32'heeec15ba;
    for (int i = 0; i < (1 << 18); i++) begin
      lcg_state                = lcg_next(lcg_state);
      vram[vram_addr_t'(i)]    = lcg_state ^ 32'(i);
    end
  endtask

  function automatic logic in_view_line(input coord_t y);
    return (y >= view_start_y) && (y < view_end_y);
  endfunction

  function automatic logic in_view_col(input coord_t x);
    return (x >= view_start_x) && (x < view_end_x);
  endfunction

  // mid mode shows every byte for two clocks, so one word lasts eight clocks.
  function automatic vram_addr_t expected_addr(input coord_t x, input coord_t y);
    int off;
    int line;
    int per_word;
    off      = int'(x) - int'(view_start_x);
    line     = int'(y) - int'(view_start_y);
    case (mode)
      MODE_HIGH_4BPP: per_word = `PIXELS_PER_WORD_4BPP;
      MODE_MID_8BPP:  per_word = 2 * `PIXELS_PER_WORD_8BPP;
      default:        per_word = `PIXELS_PER_WORD_8BPP;
    endcase
    return vram_addr_t'(int'({1'b0, page_addr}) + line * `LINE_STRIDE_WORDS + off / per_word);
  endfunction

  function automatic palette_idx_t expected_pixel(input coord_t x, input coord_t y);
    logic [31:0] word;
    int          off;
    if (!(in_view_line(y) && in_view_col(x))) begin
      return frame_col;
    end
    word = vram[expected_addr(x, y)];
    off  = int'(x) - int'(view_start_x);
    case (mode)
      MODE_HIGH_4BPP: return palette_idx_t'((word >> (4 * (off % 8))) & 32'hf);
      MODE_MID_8BPP:  return palette_idx_t'(word >> (8 * ((off % 8) / 2)));
      default:        return palette_idx_t'(word >> (8 * (off % 4)));
    endcase
  endfunction

  // ************************************************************
  // compare tasks and bookkeeping
  // ************************************************************

  task automatic check_palette(input string name, input palette_idx_t expected,
                               input palette_idx_t actual);
    checks++;
    if (actual !== expected) begin
      test_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_addr(input string name, input vram_addr_t expected,
                            input vram_addr_t actual);
    checks++;
    if (actual !== expected) begin
      test_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_coord(input string name, input coord_t expected, input coord_t actual);
    checks++;
    if (actual !== expected) begin
      test_errors++;
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      test_errors++;
      $display("CHECK FAILED %s: expected %b, actual %b at cx %0d cy %0d",
               name, expected, actual, cx, cy);
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    test_errors++;
    $display("%s: timed out waiting for %s", name, what);
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, test_errors);
    end
    errors += test_errors;
  endtask

  // display stays off for two clocks, so the raster starts again from column 0 of line 0.
  task automatic restart_display(input super_mode_t m, input logic [16:0] page,
                                 input coord_t sx, input coord_t ex,
                                 input coord_t sy, input coord_t ey,
                                 input coord_t asx, input coord_t aex,
                                 input palette_idx_t fc);
    @(posedge clk);
    super_enable <= 1'b0;
    mode         <= m;
    page_addr    <= page;
    view_start_x <= sx;
    view_end_x   <= ex;
    view_start_y <= sy;
    view_end_y   <= ey;
    arb_start_x  <= asx;
    arb_end_x    <= aex;
    frame_col    <= fc;
    repeat (2) @(posedge clk);
    super_enable <= 1'b1;
  endtask

  task automatic wait_for_position(input string name, input coord_t col, input coord_t line,
                                   input int limit);
    int guard;
    guard = 0;
    while (!((cx == col) && (cy == line)) && (guard < limit)) begin
      @(negedge clk);
      guard++;
    end
    if (!((cx == col) && (cy == line))) begin
      report_timeout(name, $sformatf("column %0d of line %0d", col, line));
    end
  endtask

  // the pixel of column x leaves the pipeline while cx shows x + 3.
  task automatic scan_picture(input string name, input coord_t last_line,
                              output int pixels, output int borders);
    int     guard;
    coord_t x;
    pixels  = 0;
    borders = 0;
    guard   = 0;
    @(negedge clk);
    while ((cy <= last_line) && (guard < (int'(last_line) + 2) * `FRAME_WIDTH_PAL)) begin
      if (cx >= 10'd3) begin
        x = cx - 10'd3;
        if (in_view_line(cy) && in_view_col(x)) begin
          pixels++;
        end else begin
          borders++;
        end
        check_palette(name, expected_pixel(x, cy), palette_addr);
      end
      if ((cx >= 10'd1) && in_view_line(cy) && in_view_col(cx - 10'd1)) begin
        check_addr(name, expected_addr(cx - 10'd1, cy), vram_addr);
      end
      @(negedge clk);
      guard++;
    end
    if (cy <= last_line) begin
      report_timeout(name, "the end of the scanned lines");
    end
  endtask

  // ************************************************************
  // tests
  // ************************************************************

  task automatic test_reset_state();
    string name;
    name        = "reset_state";
    test_errors = 0;
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      check_coord(name, '0, cx);
      check_coord(name, '0, cy);
      check_addr(name, '0, vram_addr);
      check_palette(name, '0, palette_addr);
      check_bit(name, 1'b0, drawing);
    end
    // a running picture clears again one clock after the display is switched off.
    restart_display(MODE_HIGH_8BPP, 17'h00400, 10'd20, 10'd60, 10'd2, 10'd5,
                    10'd10, 10'd50, 8'h5a);
    @(negedge clk);
    wait_for_position(name, 10'd40, 10'd3, 5 * `FRAME_WIDTH_PAL);
    @(posedge clk);
    super_enable <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      check_coord(name, '0, cx);
      check_coord(name, '0, cy);
      check_addr(name, '0, vram_addr);
      check_palette(name, '0, palette_addr);
      check_bit(name, 1'b0, drawing);
    end
    finish_test(name);
  endtask

  // pal_mode goes high with the display, yet the first frame keeps the NTSC size latched at reset.
  task automatic test_frame_wrap();
    string name;
    name        = "frame_wrap";
    test_errors = 0;
    restart_display(MODE_HIGH_8BPP, '0, 10'd20, 10'd60, 10'd2, 10'd5, 10'd1, 10'd2, 8'h00);
    pal_mode    <= 1'b1;
    @(negedge clk);
    wait_for_position(name, coord_t'(`FRAME_WIDTH_NTSC - 1), coord_t'(`FRAME_HEIGHT_NTSC - 1),
                      `FRAME_WIDTH_NTSC * (`FRAME_HEIGHT_NTSC + 1));
    @(negedge clk);
    check_coord(name, '0, cx);
    check_coord(name, '0, cy);
    wait_for_position(name, coord_t'(`FRAME_WIDTH_PAL - 1), coord_t'(`FRAME_HEIGHT_PAL - 1),
                      `FRAME_WIDTH_PAL * (`FRAME_HEIGHT_PAL + 1));
    @(negedge clk);
    check_coord(name, '0, cx);
    check_coord(name, '0, cy);
    finish_test(name);
  endtask

  task automatic run_picture_test(input string name, input super_mode_t m,
                                  input logic [16:0] page, input coord_t sx, input coord_t ex,
                                  input coord_t sy, input coord_t ey, input palette_idx_t fc);
    int pixels;
    int borders;
    int wanted;
    test_errors = 0;
    wanted      = int'(ex - sx) * int'(ey - sy);
    restart_display(m, page, sx, ex, sy, ey, 10'd1, 10'd2, fc);
    scan_picture(name, ey + 10'd1, pixels, borders);
    if ((pixels != wanted) || (borders == 0)) begin
      test_errors++;
      $display("%s: saw %0d picture and %0d border pixels, wanted %0d picture pixels",
               name, pixels, borders, wanted);
    end
    finish_test(name);
  endtask

  task automatic test_drawing();
    string name;
    int    guard;
    int    highs;
    logic  expected;
    name        = "drawing";
    test_errors = 0;
    guard       = 0;
    highs       = 0;
    restart_display(MODE_HIGH_8BPP, 17'h00400, 10'd20, 10'd60, 10'd2, 10'd5,
                    10'd30, 10'd50, 8'h11);
    @(negedge clk);
    while ((cy <= 10'd7) && (guard < 10 * `FRAME_WIDTH_PAL)) begin
      expected = in_view_line(cy) && (cx > arb_start_x) && (cx <= arb_end_x);
      check_bit(name, expected, drawing);
      if (drawing) begin
        highs++;
      end
      @(negedge clk);
      guard++;
    end
    if (cy <= 10'd7) begin
      report_timeout(name, "line 8");
    end
    if (highs != 3 * 20) begin
      test_errors++;
      $display("%s: drawing was high for %0d cycles instead of 60", name, highs);
    end
    finish_test(name);
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    super_enable = 1'b0;
    pal_mode     = 1'b0;
    mode         = MODE_HIGH_8BPP;
    page_addr    = '0;
    view_start_x = '0;
    view_end_x   = '0;
    view_start_y = '0;
    view_end_y   = '0;
    arb_start_x  = '0;
    arb_end_x    = '0;
    frame_col    = '0;
    test_errors  = 0;
    errors       = 0;
    checks       = 0;
    tests_passed = 0;
    tests_failed = 0;
    fill_vram();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_reset_state();
    test_frame_wrap();
    run_picture_test("high_8bpp", MODE_HIGH_8BPP, 17'h01234, 10'd20, 10'd60, 10'd2, 10'd5, 8'h3c);
    run_picture_test("high_4bpp", MODE_HIGH_4BPP, 17'h0a5a0, 10'd20, 10'd60, 10'd2, 10'd5, 8'h3c);
    run_picture_test("mid_8bpp", MODE_MID_8BPP, 17'h1fc00, 10'd24, 10'd56, 10'd3, 10'd6, 8'h3c);
    run_picture_test("border", MODE_HIGH_8BPP, 17'h00800, 10'd100, 10'd108, 10'd3, 10'd4, 8'ha5);
    test_drawing();
    $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
             tests_passed, tests_failed, checks, errors);
    if ((tests_failed == 0) && (errors == 0)) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/vdp_super_pkg.sv
rtl/vdp_raster_counter.sv
rtl/vdp_window_fsm.sv
super_fetch/vdp_super_addr_gen.sv
super_fetch/vdp_super_pixel_unpack.sv
rtl/vdp_super_res.sv
testbench/tb_vdp_super_res.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator; exit status follows the test result.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module tb_vdp_super_res || exit 1

sim_out="$(./obj_dir/Vtb_vdp_super_res 2>&1)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "RESULT: PASS" && exit 0 || exit 1
